// File: list.f
mulDivPkg.sv
mulDivConfig.sv
mulDivRequest.sv
mulDivEngine.sv
mulDivTop.sv
tbClock.sv
mulDivTb.sv

// File: run.sh
#!/bin/sh
# build and run the multiply/divide testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module mulDivTb \
	-Mdir obj_dir -o simMulDiv
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/simMulDiv)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Testbench passed"; then
	exit 0
fi
exit 1

// File: mulDivTb.sv
module mulDivTb;

	// edges from sampling req to ack high
	localparam int ackLatency = 68;
	localparam int ackTimeout = 200;
	localparam int dropTimeout = 10;
	localparam int resetTimeout = 20;

	logic clock;
	logic rstN;
	logic cfgWrite;
	logic cfgSigned;
	logic cfgNarrow;
	logic modeSigned;
	logic modeNarrow;
	logic req;
	mulDivPkg::mulDivOp op;
	logic [mulDivPkg::dataWidth-1:0] opA;
	logic [mulDivPkg::dataWidth-1:0] opB;
	logic ack;
	logic [mulDivPkg::dataWidth-1:0] result;

	// mode the testbench last wrote
	logic curSigned;
	logic curNarrow;
	// model value of the transaction in flight
	logic [63:0] holdExpected;
	int errorCount = 0;
	int checkCount = 0;
	integer seed = 32'hf4ea_1935;
	logic [63:0] corners [6];

	tbClock uClock
	(
		.clock(clock),
		.rstN(rstN)
	);

	mulDivTop u_dut
	(
		.clock(clock),
		.rstN(rstN),
		.cfgWrite(cfgWrite),
		.cfgSigned(cfgSigned),
		.cfgNarrow(cfgNarrow),
		.modeSigned(modeSigned),
		.modeNarrow(modeNarrow),
		.req(req),
		.op(op),
		.opA(opA),
		.opB(opB),
		.ack(ack),
		.result(result)
	);

	// ack never rises while req is low
	assert property (@(posedge clock) disable iff (!rstN) (!req && !ack) |=> !ack)
	else
	begin
		errorCount++;
		$display("Mismatch at %0t: ack expected 0 actual 1 with req low", $time);
	end

	// ack drops one cycle after req drops
	assert property (@(posedge clock) disable iff (!rstN) (ack && !req) |=> !ack)
	else
	begin
		errorCount++;
		$display("Mismatch at %0t: ack expected 0 actual 1 after req fell", $time);
	end

	// ack holds while req stays up
	assert property (@(posedge clock) disable iff (!rstN) (ack && req) |=> ack)
	else
	begin
		errorCount++;
		$display("Mismatch at %0t: ack expected 1 actual 0 with req held", $time);
	end

	// result keeps the model value while ack and req stay up
	assert property (@(posedge clock) disable iff (!rstN)
		(ack && req) |=> (result == holdExpected))
	else
	begin
		errorCount++;
		$display("Mismatch at %0t: result expected %h actual %h",
			$time, holdExpected, result);
	end

	// 32-bit value widened per signed mode
	function automatic logic [63:0] extend32(input logic [31:0] v, input logic sgn);
		extend32 = {{32{sgn & v[31]}}, v};
	endfunction

	// reference model in plain wide integer arithmetic
	function automatic logic [63:0] expectedResult(input mulDivPkg::mulDivOp kind,
		input logic [63:0] a, input logic [63:0] b, input logic sgn, input logic nar);
		logic [63:0] ea;
		logic [63:0] eb;
		logic [127:0] wa;
		logic [127:0] wb;
		logic [127:0] prod;
		logic [127:0] quot;
		logic [127:0] rem;
		logic [63:0] sel;
		ea = nar ? extend32(a[31:0], sgn) : a;
		eb = nar ? extend32(b[31:0], sgn) : b;
		wa = {{64{sgn & ea[63]}}, ea};
		wb = {{64{sgn & eb[63]}}, eb};
		// divide by zero convention
		quot = '1;
		rem = {64'b0, ea};
		if (sgn)
		begin
			prod = $signed(wa) * $signed(wb);
			if (eb != '0)
			begin
				// truncates toward zero and the remainder keeps the dividend sign
				quot = $signed(wa) / $signed(wb);
				rem = $signed(wa) % $signed(wb);
			end
		end
		else
		begin
			prod = wa * wb;
			if (eb != '0)
			begin
				quot = wa / wb;
				rem = wa % wb;
			end
		end
		case (kind)
			mulDivPkg::opMulLo: sel = prod[63:0];
			mulDivPkg::opMulHi: sel = nar ? {32'b0, prod[63:32]} : prod[127:64];
			mulDivPkg::opDiv: sel = quot[63:0];
			default: sel = rem[63:0];
		endcase
		if (nar)
		begin
			sel = extend32(sel[31:0], sgn);
		end
		expectedResult = sel;
	endfunction

	task automatic checkValue(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		checkCount++;
		assert (actual === expected)
		else
		begin
			errorCount++;
			$display("Mismatch at %0t: %s expected %h actual %h",
				$time, name, expected, actual);
		end
	endtask

	task automatic checkReset();
		int cycles;
		cycles = 0;
		while (rstN !== 1'b1 && cycles < resetTimeout)
		begin
			@(negedge clock);
			cycles++;
		end
		if (rstN !== 1'b1)
		begin
			errorCount++;
			$display("Reset was never released");
		end
		@(negedge clock);
		checkValue("ack", 64'd0, {63'b0, ack});
		checkValue("result", 64'd0, result);
		checkValue("modeSigned", 64'd0, {63'b0, modeSigned});
		checkValue("modeNarrow", 64'd0, {63'b0, modeNarrow});
	endtask

	// write both mode bits and read them back a cycle later
	task automatic writeConfig(input logic s, input logic n);
		@(posedge clock);
		cfgWrite <= 1'b1;
		cfgSigned <= s;
		cfgNarrow <= n;
		@(posedge clock);
		cfgWrite <= 1'b0;
		@(negedge clock);
		curSigned = s;
		curNarrow = n;
		checkValue("modeSigned", {63'b0, s}, {63'b0, modeSigned});
		checkValue("modeNarrow", {63'b0, n}, {63'b0, modeNarrow});
	endtask

	// one full four-phase transaction
	task automatic runOp(input mulDivPkg::mulDivOp kind, input logic [63:0] a,
		input logic [63:0] b, input int holdCycles, input logic flipMode);
		logic [63:0] expected;
		logic newSigned;
		logic newNarrow;
		int cycles;
		// mode in force when the request is accepted
		expected = expectedResult(kind, a, b, curSigned, curNarrow);
		holdExpected = expected;
		newSigned = ~curSigned;
		newNarrow = ~curNarrow;
		@(posedge clock);
		req <= 1'b1;
		op <= kind;
		opA <= a;
		opB <= b;
		if (flipMode)
		begin
			// rewrite lands while the engine runs
			fork
				writeConfig(newSigned, newNarrow);
			join_none
		end
		cycles = 0;
		do
		begin
			@(negedge clock);
			cycles++;
		end
		while (!ack && cycles < ackTimeout);
		if (!ack)
		begin
			errorCount++;
			$display("Timed out at %0t waiting for ack to rise", $time);
		end
		else
		begin
			// one negedge before the sampling edge and one after the ack edge
			checkValue("ack latency", 64'(ackLatency), 64'(cycles - 2));
			checkValue("result", expected, result);
		end
		repeat (holdCycles) @(posedge clock);
		@(posedge clock);
		req <= 1'b0;
		cycles = 0;
		do
		begin
			@(negedge clock);
			cycles++;
		end
		while (ack && cycles < dropTimeout);
		if (ack)
		begin
			errorCount++;
			$display("Timed out at %0t waiting for ack to fall", $time);
		end
	endtask

	task automatic runAllOps(input logic [63:0] a, input logic [63:0] b, input int hold);
		runOp(mulDivPkg::opMulLo, a, b, hold, 1'b0);
		runOp(mulDivPkg::opMulHi, a, b, hold, 1'b0);
		runOp(mulDivPkg::opDiv, a, b, hold, 1'b0);
		runOp(mulDivPkg::opRem, a, b, hold, 1'b0);
	endtask

	initial
	begin
		int i;
		int j;
		int m;
		logic [63:0] a;
		logic [63:0] b;
		cfgWrite = 1'b0;
		cfgSigned = 1'b0;
		cfgNarrow = 1'b0;
		req = 1'b0;
		op = mulDivPkg::opMulLo;
		opA = '0;
		opB = '0;
		curSigned = 1'b0;
		curNarrow = 1'b0;
		holdExpected = '0;
		corners[0] = 64'd0;
		corners[1] = 64'd1;
		corners[2] = '1;
		corners[3] = 64'h8000_0000_0000_0000;
		// narrow corners with junk above bit 31
		corners[4] = 64'h5a5a_5a5a_8000_0000;
		corners[5] = 64'h1234_5678_ffff_ffff;

		checkReset();

		// corners in every signed/narrow combination
		for (m = 0; m < 4; m++)
		begin
			writeConfig(m[0], m[1]);
			for (i = 0; i < 6; i++)
			begin
				for (j = 0; j < 6; j++)
				begin
					runAllOps(corners[i], corners[j], 0);
				end
			end
		end

		// random operands with some short divisors and held req
		for (m = 0; m < 4; m++)
		begin
			writeConfig(m[0], m[1]);
			for (i = 0; i < 20; i++)
			begin
				a = {$random(seed), $random(seed)};
				b = {$random(seed), $random(seed)};
				if (i % 2 == 1)
				begin
					b = b >> (i * 3);
				end
				runAllOps(a, b, i % 3);
			end
		end

		// mode rewritten mid-operation
		writeConfig(1'b1, 1'b0);
		a = {$random(seed), $random(seed)};
		b = {$random(seed), $random(seed)} >> 20;
		runOp(mulDivPkg::opDiv, a, b, 0, 1'b1);
		// next request sees unsigned narrow
		runOp(mulDivPkg::opRem, a, b, 0, 1'b0);

		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
		begin
			$display("Testbench passed");
		end
		else
		begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// File: tbClock.sv
module tbClock
(
	output logic clock,
	output logic rstN
);

	// free running, period 40
	initial
	begin
		clock = 1'b0;
		forever
		begin
			#20 clock = ~clock;
		end
	end

	// reset low for the first 4 rising edges
	initial
	begin
		rstN = 1'b0;
		repeat (4) @(posedge clock);
		rstN <= 1'b1;
	end

endmodule

// File: mulDivTop.sv
module mulDivTop
(
	input logic clock,
	input logic rstN,
	input logic cfgWrite,
	input logic cfgSigned,
	input logic cfgNarrow,
	output logic modeSigned,
	output logic modeNarrow,
	input logic req,
	input mulDivPkg::mulDivOp op,
	input logic [mulDivPkg::dataWidth-1:0] opA,
	input logic [mulDivPkg::dataWidth-1:0] opB,
	output logic ack,
	output logic [mulDivPkg::dataWidth-1:0] result
);

	// request controller to engine
	logic start;
	logic done;
	mulDivPkg::mulDivOp latOp;
	logic [mulDivPkg::dataWidth-1:0] latA;
	logic [mulDivPkg::dataWidth-1:0] latB;
	logic latSigned;
	logic latNarrow;

	// mode registers, also driven out for readback
	mulDivConfig uConfig
	(
		.clock(clock),
		.rstN(rstN),
		.cfgWrite(cfgWrite),
		.cfgSigned(cfgSigned),
		.cfgNarrow(cfgNarrow),
		.modeSigned(modeSigned),
		.modeNarrow(modeNarrow)
	);

	// handshake and operand capture
	mulDivRequest uRequest
	(
		.clock(clock),
		.rstN(rstN),
		.req(req),
		.op(op),
		.opA(opA),
		.opB(opB),
		.modeSigned(modeSigned),
		.modeNarrow(modeNarrow),
		.done(done),
		.ack(ack),
		.start(start),
		.latOp(latOp),
		.latA(latA),
		.latB(latB),
		.latSigned(latSigned),
		.latNarrow(latNarrow)
	);

	// iterative arithmetic
	mulDivEngine uEngine
	(
		.clock(clock),
		.rstN(rstN),
		.start(start),
		.latOp(latOp),
		.latA(latA),
		.latB(latB),
		.latSigned(latSigned),
		.latNarrow(latNarrow),
		.done(done),
		.result(result)
	);

endmodule

// File: mulDivEngine.sv
module mulDivEngine
(
	input logic clock,
	input logic rstN,
	input logic start,
	input mulDivPkg::mulDivOp latOp,
	input logic [mulDivPkg::dataWidth-1:0] latA,
	input logic [mulDivPkg::dataWidth-1:0] latB,
	input logic latSigned,
	input logic latNarrow,
	output logic done,
	output logic [mulDivPkg::dataWidth-1:0] result
);

	mulDivPkg::engineState stateQ;
	logic [mulDivPkg::countWidth-1:0] countQ;

	// product, or remainder (high) and quotient (low)
	logic [2*mulDivPkg::dataWidth-1:0] accQ;
	// multiplicand or divisor magnitude
	logic [mulDivPkg::dataWidth-1:0] opBQ;
	logic negProdQ;
	logic negRemQ;
	logic divZeroQ;

	logic [mulDivPkg::dataWidth-1:0] extA;
	logic [mulDivPkg::dataWidth-1:0] extB;
	logic [mulDivPkg::dataWidth-1:0] magA;
	logic [mulDivPkg::dataWidth-1:0] magB;
	logic negA;
	logic negB;
	logic isMul;
	logic [mulDivPkg::dataWidth:0] mulSum;
	logic [2*mulDivPkg::dataWidth-1:0] mulNext;
	logic [mulDivPkg::dataWidth:0] divPart;
	logic [mulDivPkg::dataWidth+1:0] divTrial;
	logic [2*mulDivPkg::dataWidth-1:0] divNext;
	logic [2*mulDivPkg::dataWidth-1:0] prodFixed;
	logic [mulDivPkg::dataWidth-1:0] quotFixed;
	logic [mulDivPkg::dataWidth-1:0] remFixed;
	logic [mulDivPkg::dataWidth-1:0] wideSel;
	logic [mulDivPkg::narrowWidth-1:0] narrowSel;
	logic [mulDivPkg::dataWidth-1:0] fixValue;

	always_comb
	begin
		// operand extension, latched inputs stay stable for the whole op
		extA = latA;
		extB = latB;
		if (latNarrow)
		begin
			extA = {{(mulDivPkg::dataWidth-mulDivPkg::narrowWidth)
				{latSigned & latA[mulDivPkg::narrowWidth-1]}},
				latA[mulDivPkg::narrowWidth-1:0]};
			extB = {{(mulDivPkg::dataWidth-mulDivPkg::narrowWidth)
				{latSigned & latB[mulDivPkg::narrowWidth-1]}},
				latB[mulDivPkg::narrowWidth-1:0]};
		end
		// magnitudes
		negA = latSigned & extA[mulDivPkg::dataWidth-1];
		negB = latSigned & extB[mulDivPkg::dataWidth-1];
		magA = negA ? -extA : extA;
		magB = negB ? -extB : extB;
		isMul = (latOp == mulDivPkg::opMulLo) || (latOp == mulDivPkg::opMulHi);

		// shift-add step, add on low bit then shift right with carry
		mulSum = {1'b0, accQ[2*mulDivPkg::dataWidth-1:mulDivPkg::dataWidth]}
			+ (accQ[0] ? {1'b0, opBQ} : '0);
		mulNext = {mulSum, accQ[mulDivPkg::dataWidth-1:1]};

		// restoring step, 65-bit partial remainder after the shift
		divPart = accQ[2*mulDivPkg::dataWidth-1:mulDivPkg::dataWidth-1];
		divTrial = {1'b0, divPart} - {2'b00, opBQ};
		if (divTrial[mulDivPkg::dataWidth+1])
		begin
			// borrow, keep partial and shift in a zero
			divNext = {divPart[mulDivPkg::dataWidth-1:0],
				accQ[mulDivPkg::dataWidth-2:0], 1'b0};
		end
		else
		begin
			divNext = {divTrial[mulDivPkg::dataWidth-1:0],
				accQ[mulDivPkg::dataWidth-2:0], 1'b1};
		end

		// sign fix-up
		prodFixed = negProdQ ? -accQ : accQ;
		quotFixed = negProdQ ? -accQ[mulDivPkg::dataWidth-1:0]
			: accQ[mulDivPkg::dataWidth-1:0];
		remFixed = negRemQ ? -accQ[2*mulDivPkg::dataWidth-1:mulDivPkg::dataWidth]
			: accQ[2*mulDivPkg::dataWidth-1:mulDivPkg::dataWidth];
		if (divZeroQ)
		begin
			// divide by zero convention
			quotFixed = '1;
			remFixed = extA;
		end

		case (latOp)
			mulDivPkg::opMulLo: wideSel = prodFixed[mulDivPkg::dataWidth-1:0];
			mulDivPkg::opMulHi:
				wideSel = prodFixed[2*mulDivPkg::dataWidth-1:mulDivPkg::dataWidth];
			mulDivPkg::opDiv: wideSel = quotFixed;
			default: wideSel = remFixed;
		endcase

		// narrow high product lives in bits 63..32
		if (latOp == mulDivPkg::opMulHi)
		begin
			narrowSel = prodFixed[mulDivPkg::dataWidth-1:mulDivPkg::narrowWidth];
		end
		else
		begin
			narrowSel = wideSel[mulDivPkg::narrowWidth-1:0];
		end
		fixValue = wideSel;
		if (latNarrow)
		begin
			fixValue = {{(mulDivPkg::dataWidth-mulDivPkg::narrowWidth)
				{latSigned & narrowSel[mulDivPkg::narrowWidth-1]}}, narrowSel};
		end
	end

	// control FSM, prep 1 + loop 64 + fix 1
	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			stateQ <= mulDivPkg::stIdle;
			countQ <= '0;
			done <= 1'b0;
			result <= '0;
		end
		else
		begin
			done <= 1'b0;
			case (stateQ)
				mulDivPkg::stIdle:
				begin
					if (start)
					begin
						stateQ <= mulDivPkg::stPrep;
					end
				end
				mulDivPkg::stPrep:
				begin
					countQ <= mulDivPkg::iterCount;
					stateQ <= mulDivPkg::stLoop;
				end
				mulDivPkg::stLoop:
				begin
					countQ <= countQ - 1'b1;
					// last iteration
					if (countQ == 1)
					begin
						stateQ <= mulDivPkg::stFix;
					end
				end
				default:
				begin
					// result held until the next operation
					result <= fixValue;
					done <= 1'b1;
					stateQ <= mulDivPkg::stIdle;
				end
			endcase
		end
	end

	// datapath registers
	always_ff @(posedge clock)
	begin
		if (stateQ == mulDivPkg::stPrep)
		begin
			accQ <= {{mulDivPkg::dataWidth{1'b0}}, magA};
			opBQ <= magB;
			negProdQ <= negA ^ negB;
			// remainder follows the dividend
			negRemQ <= negA;
			divZeroQ <= (extB == '0);
		end
		else if (stateQ == mulDivPkg::stLoop)
		begin
			accQ <= isMul ? mulNext : divNext;
		end
	end

endmodule

// File: mulDivRequest.sv
module mulDivRequest
(
	input logic clock,
	input logic rstN,

	// four-phase request side
	input logic req,
	input mulDivPkg::mulDivOp op,
	input logic [mulDivPkg::dataWidth-1:0] opA,
	input logic [mulDivPkg::dataWidth-1:0] opB,
	input logic modeSigned,
	input logic modeNarrow,

	// engine finished, one cycle
	input logic done,

	output logic ack,

	// engine kick, one cycle
	output logic start,
	output mulDivPkg::mulDivOp latOp,
	output logic [mulDivPkg::dataWidth-1:0] latA,
	output logic [mulDivPkg::dataWidth-1:0] latB,
	output logic latSigned,
	output logic latNarrow
);

	mulDivPkg::reqState stateQ;

	// handshake FSM
	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			stateQ <= mulDivPkg::rsIdle;
			ack <= 1'b0;
			start <= 1'b0;
		end
		else
		begin
			// start is a single pulse
			start <= 1'b0;
			case (stateQ)
				mulDivPkg::rsIdle:
				begin
					if (req)
					begin
						start <= 1'b1;
						stateQ <= mulDivPkg::rsBusy;
					end
				end
				mulDivPkg::rsBusy:
				begin
					// result already registered in the engine
					if (done)
					begin
						ack <= 1'b1;
						stateQ <= mulDivPkg::rsAck;
					end
				end
				mulDivPkg::rsAck:
				begin
					// hold ack while master keeps req up
					if (!req)
					begin
						ack <= 1'b0;
						stateQ <= mulDivPkg::rsDrop;
					end
				end
				default:
				begin
					// one guard cycle after ack falls
					stateQ <= mulDivPkg::rsIdle;
				end
			endcase
		end
	end

	// operands, opcode and mode captured once per request
	always_ff @(posedge clock)
	begin
		if ((stateQ == mulDivPkg::rsIdle) && req)
		begin
			latOp <= op;
			latA <= opA;
			latB <= opB;
			latSigned <= modeSigned;
			latNarrow <= modeNarrow;
		end
	end

endmodule

// File: mulDivConfig.sv
module mulDivConfig
(
	input logic clock,
	input logic rstN,

	// write strobe, both bits written together
	input logic cfgWrite,
	input logic cfgSigned,
	input logic cfgNarrow,

	// current mode, also the readback path
	output logic modeSigned,
	output logic modeNarrow
);

	// mode register
	// signed operands and results when set
	// low 32 bits only when narrow is set
	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			// unsigned, wide after reset
			modeSigned <= 1'b0;
			modeNarrow <= 1'b0;
		end
		else if (cfgWrite)
		begin
			// new mode visible next cycle
			modeSigned <= cfgSigned;
			modeNarrow <= cfgNarrow;
		end
	end

	// the request side latches these at request start,
	// so a rewrite mid-operation only affects the next request

endmodule

// File: mulDivPkg.sv
package mulDivPkg;

	// operand and result width
	localparam int dataWidth = 64;

	// operand width when narrow mode is set
	localparam int narrowWidth = 32;

	// iteration counter, wide enough to hold the full count
	localparam int countWidth = 7;

	// one bit per clock in the loop
	localparam logic [countWidth-1:0] iterCount = 7'd64;

	// operations
	typedef enum logic [1:0]
	{
		// low half of product
		opMulLo = 2'd0,
		// high half of product
		opMulHi = 2'd1,
		// quotient
		opDiv = 2'd2,
		// remainder
		opRem = 2'd3
	} mulDivOp;

	// arithmetic engine states
	typedef enum logic [1:0]
	{
		stIdle = 2'd0,
		stPrep = 2'd1,
		stLoop = 2'd2,
		stFix = 2'd3
	} engineState;

	// four-phase handshake states
	typedef enum logic [1:0]
	{
		rsIdle = 2'd0,
		rsBusy = 2'd1,
		rsAck = 2'd2,
		rsDrop = 2'd3
	} reqState;

endpackage
